// File: design/harmonics_pkg.sv
package harmonics_pkg;

	// default sizes of the estimator
	localparam int HARMONICS_NUM = 26;
	localparam int IN_SERIES_NUM = 3;
	localparam int QMATH_SHIFT = 2;

	// word widths of the datapath
	localparam int DATA_W = 18;
	localparam int ACC_W = 40;

	localparam int STATE_ADDR_W = 9;
	localparam int COEF_ADDR_W = 9;

	// state memory holds x1 and x2 per harmonic with the sum after them
	localparam int STATE_SLOTS = 2;
	localparam int STATE_SUM_ADDR = STATE_SLOTS * HARMONICS_NUM;

	// coefficient memory holds cos, sin, k1, k2 per harmonic and then one sample per series
	localparam int COEF_SLOTS = 4;
	localparam int COEF_SAMPLE_BASE = COEF_SLOTS * HARMONICS_NUM;

	localparam int SLOT_W = 2;

	localparam logic [SLOT_W-1:0] X1_SLOT = 2'd0;
	localparam logic [SLOT_W-1:0] X2_SLOT = 2'd1;
	localparam logic [SLOT_W-1:0] COS_SLOT = 2'd0;
	localparam logic [SLOT_W-1:0] SIN_SLOT = 2'd1;
	localparam logic [SLOT_W-1:0] K1_SLOT = 2'd2;
	localparam logic [SLOT_W-1:0] K2_SLOT = 2'd3;
	localparam logic [SLOT_W-1:0] SUM_SLOT = 2'd0;
	localparam logic [SLOT_W-1:0] SAMPLE_SLOT = 2'd0;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	typedef enum logic [2:0] {
		NOP,
		LOAD_MUL,
		ADD_MUL,
		SUB_MUL,
		LOAD_ERR,
		ADD_SUM,
		CLEAR_SUM
	} mac_op_e;

	// second multiplier operand
	typedef enum logic [1:0] {
		SEL_COEF,
		SEL_ERR,
		SEL_ONE
	} operand_sel_e;

	// what lands in the state memory on a write
	typedef enum logic [1:0] {
		WR_MAC,
		WR_SUM,
		WR_ZERO
	} wr_src_e;

	typedef struct packed {
		mac_op_e op;
		operand_sel_e b_sel;
		logic wr_en;
		wr_src_e wr_src;
	} ctrl_word_t;

	// common selects the shared area (sum or samples) instead of the harmonic's own slots
	typedef struct packed {
		logic common;
		logic [SLOT_W-1:0] slot;
	} slot_ptr_t;

	typedef struct packed {
		logic valid;
		logic [STATE_ADDR_W-1:0] addr;
		data_t data;
	} mem_wr_t;

	// counter width that stays legal for a count of one
	function automatic int idx_w(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

// File: design/pipeline_delay.sv
`timescale 1ns/100ps

module pipeline_delay #(
	parameter type T = logic,
	parameter int CYCLES = 1
) (
	input logic clk_i,
	input logic harmonics_rst,
	input T d_i,
	output T q_o
);
	T stage_q [CYCLES];

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			// an empty line means no stray write enable after reset
			for (int i = 0; i < CYCLES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= d_i;
			for (int i = 1; i < CYCLES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign q_o = stage_q[CYCLES-1];

endmodule

// File: design/dual_port_ram.sv
`timescale 1ns/100ps

module dual_port_ram #(
	parameter type T = harmonics_pkg::data_t,
	parameter int DEPTH = 2 ** harmonics_pkg::STATE_ADDR_W
) (
	input logic clk_i,
	input harmonics_pkg::mem_wr_t wr_i,
	input logic [$clog2(DEPTH)-1:0] rd_addr_i,
	output T rd_data_o
);
	T mem_q [DEPTH];

	// a read of the address being written returns the old word
	always_ff @(posedge clk_i) begin
		if (wr_i.valid) begin
			mem_q[wr_i.addr] <= T'(wr_i.data);
		end
		rd_data_o <= mem_q[rd_addr_i];
	end

endmodule

// File: design/slot_addr_gen.sv
`timescale 1ns/100ps

module slot_addr_gen #(
	parameter int HARMONICS_NUM = harmonics_pkg::HARMONICS_NUM,
	parameter int IN_SERIES_NUM = harmonics_pkg::IN_SERIES_NUM,
	parameter int SLOTS = harmonics_pkg::STATE_SLOTS,
	parameter int COMMON_BASE = harmonics_pkg::STATE_SUM_ADDR,
	parameter int SERIES_STEP = 0,
	parameter int ADDR_W = harmonics_pkg::STATE_ADDR_W
) (
	input logic clk_i,
	input harmonics_pkg::slot_ptr_t ptr_i,
	input logic [harmonics_pkg::idx_w(HARMONICS_NUM)-1:0] harmonic_i,
	input logic [harmonics_pkg::idx_w(IN_SERIES_NUM)-1:0] series_i,
	output logic [ADDR_W-1:0] addr_o
);
	logic [ADDR_W-1:0] harmonic_addr;
	logic [ADDR_W-1:0] common_addr;

	// each harmonic owns SLOTS consecutive words from address zero
	assign harmonic_addr = ADDR_W'(harmonic_i) * ADDR_W'(SLOTS) + ADDR_W'(ptr_i.slot);

	// the common area can advance with the series index, as the samples do
	assign common_addr = ADDR_W'(COMMON_BASE) + ADDR_W'(ptr_i.slot)
		+ ADDR_W'(series_i) * ADDR_W'(SERIES_STEP);

	always_ff @(posedge clk_i) begin
		addr_o <= ptr_i.common ? common_addr : harmonic_addr;
	end

endmodule

// File: design/mac_datapath.sv
`timescale 1ns/100ps

module mac_datapath #(
	parameter int QMATH_SHIFT = harmonics_pkg::QMATH_SHIFT
) (
	input logic clk_i,
	input logic harmonics_rst,
	input harmonics_pkg::ctrl_word_t ctrl_i,
	input harmonics_pkg::data_t state_rd_i,
	input harmonics_pkg::data_t coef_rd_i,
	output harmonics_pkg::data_t result_o
);
	harmonics_pkg::ctrl_word_t ctrl_s1_q;
	harmonics_pkg::ctrl_word_t ctrl_s2_q;

	harmonics_pkg::data_t mul_a;
	harmonics_pkg::data_t mul_b;
	harmonics_pkg::acc_t prod_q;
	harmonics_pkg::data_t coef_q;

	harmonics_pkg::acc_t acc_next;
	harmonics_pkg::acc_t acc_q;
	harmonics_pkg::data_t err_q;
	harmonics_pkg::data_t sum_q;

	// arithmetic shift then keep the low DATA_W bits
	function automatic harmonics_pkg::data_t shift_wrap(input harmonics_pkg::acc_t value);
		return harmonics_pkg::data_t'(value >>> QMATH_SHIFT);
	endfunction

	// the error term pairs the gain coefficient with the error register
	always_comb begin
		mul_a = state_rd_i;
		mul_b = coef_rd_i;
		case (ctrl_i.b_sel)
			harmonics_pkg::SEL_ERR: begin
				mul_a = coef_rd_i;
				mul_b = err_q;
			end
			harmonics_pkg::SEL_ONE: mul_b = harmonics_pkg::data_t'(1);
			default: ;
		endcase
	end

	always_ff @(posedge clk_i) begin
		prod_q <= harmonics_pkg::acc_t'(mul_a) * harmonics_pkg::acc_t'(mul_b);
		coef_q <= coef_rd_i;
	end

	always_comb begin
		case (ctrl_s1_q.op)
			harmonics_pkg::LOAD_MUL: acc_next = prod_q;
			harmonics_pkg::ADD_MUL, harmonics_pkg::ADD_SUM: acc_next = acc_q + prod_q;
			harmonics_pkg::SUB_MUL: acc_next = acc_q - prod_q;
			default: acc_next = acc_q;
		endcase
	end

	always_ff @(posedge clk_i) begin
		acc_q <= acc_next;
		if (ctrl_s1_q.op == harmonics_pkg::ADD_SUM) begin
			sum_q <= sum_q + shift_wrap(acc_next);
		end
		if (ctrl_s1_q.op == harmonics_pkg::CLEAR_SUM) begin
			sum_q <= '0;
		end
		// sample minus stored sum, the sum came through the multiplier times one
		if (ctrl_s1_q.op == harmonics_pkg::LOAD_ERR) begin
			err_q <= coef_q - harmonics_pkg::data_t'(prod_q);
		end
	end

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			ctrl_s1_q <= '0;
			ctrl_s2_q <= '0;
		end else begin
			ctrl_s1_q <= ctrl_i;
			ctrl_s2_q <= ctrl_s1_q;
		end
	end

	always_comb begin
		case (ctrl_s2_q.wr_src)
			harmonics_pkg::WR_MAC: result_o = shift_wrap(acc_q);
			harmonics_pkg::WR_SUM: result_o = sum_q;
			default: result_o = '0;
		endcase
	end

endmodule

// File: design/harmonics_sequencer.sv
`timescale 1ns/100ps

module harmonics_sequencer #(
	parameter int HARMONICS_NUM = harmonics_pkg::HARMONICS_NUM,
	parameter int IN_SERIES_NUM = harmonics_pkg::IN_SERIES_NUM
) (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_req_i,
	output logic start_ack_o,
	output harmonics_pkg::ctrl_word_t ctrl_o,
	output harmonics_pkg::slot_ptr_t state_rd_ptr_o,
	output harmonics_pkg::slot_ptr_t coef_rd_ptr_o,
	output harmonics_pkg::slot_ptr_t state_wr_ptr_o,
	output logic [harmonics_pkg::idx_w(HARMONICS_NUM)-1:0] harmonic_o,
	output logic [harmonics_pkg::idx_w(IN_SERIES_NUM)-1:0] series_o,
	output logic busy_o
);
	localparam int HARM_W = harmonics_pkg::idx_w(HARMONICS_NUM);
	localparam int SER_W = harmonics_pkg::idx_w(IN_SERIES_NUM);
	localparam logic [HARM_W-1:0] LAST_HARMONIC = HARM_W'(HARMONICS_NUM - 1);
	localparam logic [SER_W-1:0] LAST_SERIES = SER_W'(IN_SERIES_NUM - 1);
	// the sum write needs four cycles to land before the next error step reads it
	localparam logic [2:0] DRAIN_LAST = 3'd3;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CLEAR,
		ST_ERR,
		ST_CLR_SUM,
		ST_HARM,
		ST_SUM_WR,
		ST_DRAIN,
		ST_ACK
	} seq_state_e;

	seq_state_e state_q;
	logic [2:0] step_q;
	logic [2:0] last_step;
	logic [HARM_W-1:0] harmonic_q;
	logic [SER_W-1:0] series_q;
	logic cleared_q;

	function automatic harmonics_pkg::slot_ptr_t own_slot(
		input logic [harmonics_pkg::SLOT_W-1:0] slot
	);
		return '{common: 1'b0, slot: slot};
	endfunction

	function automatic harmonics_pkg::slot_ptr_t common_slot(
		input logic [harmonics_pkg::SLOT_W-1:0] slot
	);
		return '{common: 1'b1, slot: slot};
	endfunction

	// clearing writes two slots per harmonic, an update takes six steps
	assign last_step = (state_q == ST_CLEAR) ? 3'd1 : 3'd5;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_q <= ST_IDLE;
			step_q <= '0;
			harmonic_q <= '0;
			series_q <= '0;
			cleared_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (start_req_i) begin
						state_q <= cleared_q ? ST_ERR : ST_CLEAR;
						step_q <= '0;
						harmonic_q <= '0;
						series_q <= '0;
					end
				end
				ST_CLEAR, ST_HARM: begin
					if (step_q == last_step) begin
						step_q <= '0;
						if (harmonic_q == LAST_HARMONIC) begin
							harmonic_q <= '0;
							state_q <= ST_SUM_WR;
						end else begin
							harmonic_q <= harmonic_q + 1'b1;
						end
					end else begin
						step_q <= step_q + 3'd1;
					end
				end
				ST_ERR: state_q <= ST_CLR_SUM;
				ST_CLR_SUM: state_q <= ST_HARM;
				ST_SUM_WR: state_q <= ST_DRAIN;
				ST_DRAIN: begin
					if (step_q == DRAIN_LAST) begin
						step_q <= '0;
						if (!cleared_q) begin
							// clearing pass is over so the first series starts now
							cleared_q <= 1'b1;
							state_q <= ST_ERR;
						end else if (series_q == LAST_SERIES) begin
							series_q <= '0;
							state_q <= ST_ACK;
						end else begin
							series_q <= series_q + 1'b1;
							state_q <= ST_ERR;
						end
					end else begin
						step_q <= step_q + 3'd1;
					end
				end
				ST_ACK: begin
					if (!start_req_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// microcode decode of the current step
	always_comb begin
		ctrl_o = '0;
		state_rd_ptr_o = '0;
		coef_rd_ptr_o = '0;
		state_wr_ptr_o = '0;
		case (state_q)
			ST_CLEAR: begin
				ctrl_o.wr_en = 1'b1;
				ctrl_o.wr_src = harmonics_pkg::WR_ZERO;
				state_wr_ptr_o = own_slot(step_q[0] ? harmonics_pkg::X2_SLOT : harmonics_pkg::X1_SLOT);
			end
			ST_ERR: begin
				ctrl_o.op = harmonics_pkg::LOAD_ERR;
				ctrl_o.b_sel = harmonics_pkg::SEL_ONE;
				state_rd_ptr_o = common_slot(harmonics_pkg::SUM_SLOT);
				coef_rd_ptr_o = common_slot(harmonics_pkg::SAMPLE_SLOT);
			end
			ST_CLR_SUM: ctrl_o.op = harmonics_pkg::CLEAR_SUM;
			ST_HARM: begin
				case (step_q)
					3'd0: begin
						ctrl_o.op = harmonics_pkg::LOAD_MUL;
						state_rd_ptr_o = own_slot(harmonics_pkg::X1_SLOT);
						coef_rd_ptr_o = own_slot(harmonics_pkg::COS_SLOT);
					end
					3'd1: begin
						ctrl_o.op = harmonics_pkg::SUB_MUL;
						state_rd_ptr_o = own_slot(harmonics_pkg::X2_SLOT);
						coef_rd_ptr_o = own_slot(harmonics_pkg::SIN_SLOT);
					end
					3'd2: begin
						// closes x1 and folds the new value into the sum
						ctrl_o.op = harmonics_pkg::ADD_SUM;
						ctrl_o.b_sel = harmonics_pkg::SEL_ERR;
						ctrl_o.wr_en = 1'b1;
						coef_rd_ptr_o = own_slot(harmonics_pkg::K1_SLOT);
						state_wr_ptr_o = own_slot(harmonics_pkg::X1_SLOT);
					end
					3'd3: begin
						// this read still sees the old x1 because its write lands three cycles later
						ctrl_o.op = harmonics_pkg::LOAD_MUL;
						state_rd_ptr_o = own_slot(harmonics_pkg::X1_SLOT);
						coef_rd_ptr_o = own_slot(harmonics_pkg::SIN_SLOT);
					end
					3'd4: begin
						ctrl_o.op = harmonics_pkg::ADD_MUL;
						state_rd_ptr_o = own_slot(harmonics_pkg::X2_SLOT);
						coef_rd_ptr_o = own_slot(harmonics_pkg::COS_SLOT);
					end
					default: begin
						ctrl_o.op = harmonics_pkg::ADD_MUL;
						ctrl_o.b_sel = harmonics_pkg::SEL_ERR;
						ctrl_o.wr_en = 1'b1;
						coef_rd_ptr_o = own_slot(harmonics_pkg::K2_SLOT);
						state_wr_ptr_o = own_slot(harmonics_pkg::X2_SLOT);
					end
				endcase
			end
			ST_SUM_WR: begin
				ctrl_o.wr_en = 1'b1;
				ctrl_o.wr_src = cleared_q ? harmonics_pkg::WR_SUM : harmonics_pkg::WR_ZERO;
				state_wr_ptr_o = common_slot(harmonics_pkg::SUM_SLOT);
			end
			default: ;
		endcase
	end

	assign start_ack_o = (state_q == ST_ACK);
	assign busy_o = (state_q != ST_IDLE);
	assign harmonic_o = harmonic_q;
	assign series_o = series_q;

endmodule

// File: design/harmonics_top.sv
`timescale 1ns/100ps

module harmonics_top #(
	parameter int HARMONICS_NUM = harmonics_pkg::HARMONICS_NUM,
	parameter int IN_SERIES_NUM = harmonics_pkg::IN_SERIES_NUM,
	parameter int QMATH_SHIFT = harmonics_pkg::QMATH_SHIFT
) (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_req_i,
	output logic start_ack_o,
	input harmonics_pkg::mem_wr_t coef_wr_i,
	output harmonics_pkg::mem_wr_t state_wr_o
);
	localparam int HARM_W = harmonics_pkg::idx_w(HARMONICS_NUM);
	localparam int SER_W = harmonics_pkg::idx_w(IN_SERIES_NUM);
	localparam int STATE_ADDR_W = harmonics_pkg::STATE_ADDR_W;
	localparam int COEF_ADDR_W = harmonics_pkg::COEF_ADDR_W;

	harmonics_pkg::ctrl_word_t seq_ctrl;
	harmonics_pkg::ctrl_word_t mac_ctrl;
	harmonics_pkg::slot_ptr_t state_rd_ptr;
	harmonics_pkg::slot_ptr_t coef_rd_ptr;
	harmonics_pkg::slot_ptr_t state_wr_ptr;
	logic [HARM_W-1:0] harmonic;
	logic [SER_W-1:0] series;
	logic busy;

	logic [STATE_ADDR_W-1:0] state_rd_addr;
	logic [STATE_ADDR_W-1:0] state_wr_addr;
	logic [STATE_ADDR_W-1:0] state_wr_addr_d;
	logic [COEF_ADDR_W-1:0] coef_rd_addr;
	logic wr_en_d;

	harmonics_pkg::data_t state_rd_data;
	harmonics_pkg::data_t coef_rd_data;
	harmonics_pkg::data_t mac_result;
	harmonics_pkg::mem_wr_t coef_wr;
	harmonics_pkg::mem_wr_t state_wr;

	// coefficients may only change while the handshake is idle
	assign coef_wr = '{
		valid: coef_wr_i.valid & ~start_req_i & ~start_ack_o & ~busy,
		addr: coef_wr_i.addr,
		data: coef_wr_i.data
	};

	assign state_wr = '{valid: wr_en_d, addr: state_wr_addr_d, data: mac_result};
	assign state_wr_o = state_wr;

	harmonics_sequencer #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.IN_SERIES_NUM(IN_SERIES_NUM)
	) u_sequencer (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.start_req_i(start_req_i),
		.start_ack_o(start_ack_o),
		.ctrl_o(seq_ctrl),
		.state_rd_ptr_o(state_rd_ptr),
		.coef_rd_ptr_o(coef_rd_ptr),
		.state_wr_ptr_o(state_wr_ptr),
		.harmonic_o(harmonic),
		.series_o(series),
		.busy_o(busy)
	);

	// the sum slot stays put from series to series
	slot_addr_gen #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.IN_SERIES_NUM(IN_SERIES_NUM),
		.SLOTS(harmonics_pkg::STATE_SLOTS),
		.COMMON_BASE(harmonics_pkg::STATE_SLOTS * HARMONICS_NUM),
		.SERIES_STEP(0),
		.ADDR_W(STATE_ADDR_W)
	) u_state_rd_addr (
		.clk_i(clk_i),
		.ptr_i(state_rd_ptr),
		.harmonic_i(harmonic),
		.series_i(series),
		.addr_o(state_rd_addr)
	);

	slot_addr_gen #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.IN_SERIES_NUM(IN_SERIES_NUM),
		.SLOTS(harmonics_pkg::STATE_SLOTS),
		.COMMON_BASE(harmonics_pkg::STATE_SLOTS * HARMONICS_NUM),
		.SERIES_STEP(0),
		.ADDR_W(STATE_ADDR_W)
	) u_state_wr_addr (
		.clk_i(clk_i),
		.ptr_i(state_wr_ptr),
		.harmonic_i(harmonic),
		.series_i(series),
		.addr_o(state_wr_addr)
	);

	// samples follow the coefficients, one word per series
	slot_addr_gen #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.IN_SERIES_NUM(IN_SERIES_NUM),
		.SLOTS(harmonics_pkg::COEF_SLOTS),
		.COMMON_BASE(harmonics_pkg::COEF_SLOTS * HARMONICS_NUM),
		.SERIES_STEP(1),
		.ADDR_W(COEF_ADDR_W)
	) u_coef_rd_addr (
		.clk_i(clk_i),
		.ptr_i(coef_rd_ptr),
		.harmonic_i(harmonic),
		.series_i(series),
		.addr_o(coef_rd_addr)
	);

	// address register plus ram read puts the read data two cycles after issue
	pipeline_delay #(
		.T(harmonics_pkg::ctrl_word_t),
		.CYCLES(2)
	) u_ctrl_delay (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.d_i(seq_ctrl),
		.q_o(mac_ctrl)
	);

	// two more cycles through the multiply and accumulate stages
	pipeline_delay #(
		.T(logic),
		.CYCLES(2)
	) u_wr_en_delay (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.d_i(mac_ctrl.wr_en),
		.q_o(wr_en_d)
	);

	pipeline_delay #(
		.T(logic [STATE_ADDR_W-1:0]),
		.CYCLES(3)
	) u_wr_addr_delay (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.d_i(state_wr_addr),
		.q_o(state_wr_addr_d)
	);

	dual_port_ram #(
		.T(harmonics_pkg::data_t),
		.DEPTH(2 ** STATE_ADDR_W)
	) u_state_ram (
		.clk_i(clk_i),
		.wr_i(state_wr),
		.rd_addr_i(state_rd_addr),
		.rd_data_o(state_rd_data)
	);

	dual_port_ram #(
		.T(harmonics_pkg::data_t),
		.DEPTH(2 ** COEF_ADDR_W)
	) u_coef_ram (
		.clk_i(clk_i),
		.wr_i(coef_wr),
		.rd_addr_i(coef_rd_addr),
		.rd_data_o(coef_rd_data)
	);

	mac_datapath #(
		.QMATH_SHIFT(QMATH_SHIFT)
	) u_mac (
		.clk_i(clk_i),
		.harmonics_rst(harmonics_rst),
		.ctrl_i(mac_ctrl),
		.state_rd_i(state_rd_data),
		.coef_rd_i(coef_rd_data),
		.result_o(mac_result)
	);

endmodule

// File: include/harmonics_tb_tasks.svh
`ifndef HARMONICS_TB_TASKS_SVH
`define HARMONICS_TB_TASKS_SVH

task automatic check_state_wr(input harmonics_pkg::mem_wr_t got,
	input harmonics_pkg::mem_wr_t exp);
	if (got !== exp) begin
		report_failure($sformatf(
			"MISMATCH at %0t state_wr_o: got %0b/%0d/%0d, expected %0b/%0d/%0d",
			$time, got.valid, got.addr, got.data, exp.valid, exp.addr, exp.data));
	end
endtask

task automatic check_ack(input logic got, input logic exp);
	if (got !== exp) begin
		report_failure($sformatf("MISMATCH at %0t start_ack_o: got %0b, expected %0b",
			$time, got, exp));
	end
endtask

task automatic check_wr_idle(input logic got);
	if (got !== 1'b0) begin
		report_failure($sformatf("MISMATCH at %0t state_wr_o.valid: got %0b, expected 0",
			$time, got));
	end
endtask

task automatic apply_reset();
	@(posedge clk);
	#DRIVE_DLY;
	harmonics_rst = 1'b1;
	repeat (RESET_CYCLES) @(posedge clk);
	#DRIVE_DLY;
	harmonics_rst = 1'b0;
	cleared_m = 1'b0;
endtask

// with req low the DUT stays silent
task automatic test_reset_quiet();
	repeat (8) begin
		@(negedge clk);
		check_ack(start_ack, 1'b0);
		check_wr_idle(state_wr.valid);
	end
endtask

task automatic drive_idle();
	@(posedge clk);
	#DRIVE_DLY;
	coef_wr = '0;
endtask

task automatic write_coef(input int addr, input harmonics_pkg::data_t data);
	@(posedge clk);
	#DRIVE_DLY;
	coef_wr = '{valid: 1'b1, addr: ADDR_W'(addr), data: data};
	coef_m[addr] = data;
endtask

task automatic load_coefficients();
	for (int a = 0; a < SAMPLE_BASE; a++) begin
		write_coef(a, harmonics_pkg::data_t'($urandom));
	end
	drive_idle();
endtask

task automatic load_samples();
	for (int s = 0; s < IN_SERIES_NUM; s++) begin
		write_coef(SAMPLE_BASE + s, harmonics_pkg::data_t'($urandom));
	end
	drive_idle();
endtask

// one full handshake, checking every state write and the ack edges
task automatic run_estimator(input bit poke_busy);
	harmonics_pkg::mem_wr_t expected;
	bit acked;
	predict_run();
	@(posedge clk);
	#DRIVE_DLY;
	start_req = 1'b1;
	acked = 1'b0;
	while (!acked) begin
		@(negedge clk);
		if (state_wr.valid) begin
			if (exp_q.size() == 0) begin
				report_failure("ERROR: state write after the last expected write of the run");
			end
			expected = exp_q.pop_front();
			check_state_wr(state_wr, expected);
		end
		if (start_ack) begin
			if (exp_q.size() != 0) begin
				report_failure($sformatf("ERROR: ack rose with %0d state writes missing",
					exp_q.size()));
			end
			acked = 1'b1;
		end else if (poke_busy) begin
			// these land nowhere because the run is in progress
			@(posedge clk);
			#DRIVE_DLY;
			coef_wr = '{valid: 1'b1, addr: ADDR_W'($urandom_range(0, COEF_WORDS - 1)),
				data: harmonics_pkg::data_t'($urandom)};
		end
	end
	@(posedge clk);
	#DRIVE_DLY;
	start_req = 1'b0;
	coef_wr = '0;
	@(negedge clk);
	check_ack(start_ack, 1'b1);
	check_wr_idle(state_wr.valid);
	@(negedge clk);
	check_ack(start_ack, 1'b0);
	check_wr_idle(state_wr.valid);
endtask

`endif

// File: tests/harmonics_tb.sv
`timescale 1ns/100ps

module harmonics_tb;

	localparam int HARMONICS_NUM = harmonics_pkg::HARMONICS_NUM;
	localparam int IN_SERIES_NUM = harmonics_pkg::IN_SERIES_NUM;
	localparam int QMATH_SHIFT = harmonics_pkg::QMATH_SHIFT;
	localparam int ADDR_W = harmonics_pkg::STATE_ADDR_W;
	localparam int SUM_ADDR = harmonics_pkg::STATE_SLOTS * HARMONICS_NUM;
	localparam int SAMPLE_BASE = harmonics_pkg::COEF_SLOTS * HARMONICS_NUM;
	localparam int COEF_WORDS = SAMPLE_BASE + IN_SERIES_NUM;
	localparam int SEED = 25;
	localparam int RESET_CYCLES = 4;
	localparam time DRIVE_DLY = 1ns;

	// a clearing pass and every series each write all state slots once
	localparam int PASS_WRITES = 2 * HARMONICS_NUM + 1;
	// three issue cycles per write, plus error, sum and drain steps per series
	localparam int RUN_CYCLES = PASS_WRITES + 5 + IN_SERIES_NUM * (3 * PASS_WRITES + 4) + 8;
	// three runs, three resets and every coefficient write, with a factor of two to spare
	localparam int TIMEOUT_CYCLES = 2 * (3 * (RESET_CYCLES + 8) + 3 * RUN_CYCLES + 3 * COEF_WORDS);

	logic clk;
	logic harmonics_rst;
	logic start_req;
	logic start_ack;
	harmonics_pkg::mem_wr_t coef_wr;
	harmonics_pkg::mem_wr_t state_wr;

	// reference model of both memories and the estimator state
	harmonics_pkg::data_t coef_m [COEF_WORDS];
	harmonics_pkg::data_t x1_m [HARMONICS_NUM];
	harmonics_pkg::data_t x2_m [HARMONICS_NUM];
	harmonics_pkg::data_t sum_m;
	bit cleared_m;
	harmonics_pkg::mem_wr_t exp_q [$];

	int unsigned cycle_count = 0;
	int unsigned fail_count = 0;

	harmonics_top #(
		.HARMONICS_NUM(HARMONICS_NUM),
		.IN_SERIES_NUM(IN_SERIES_NUM),
		.QMATH_SHIFT(QMATH_SHIFT)
	) dut (
		.clk_i(clk),
		.harmonics_rst(harmonics_rst),
		.start_req_i(start_req),
		.start_ack_o(start_ack),
		.coef_wr_i(coef_wr),
		.state_wr_o(state_wr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			report_failure($sformatf("ERROR: timeout after %0d cycles", cycle_count));
		end
	end

	task automatic report_failure(input string line);
		fail_count++;
		$display("%s", line);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic push_write(input int addr, input harmonics_pkg::data_t data);
		harmonics_pkg::mem_wr_t entry;
		entry = '{valid: 1'b1, addr: ADDR_W'(addr), data: data};
		exp_q.push_back(entry);
	endtask

	// expected state writes of one run, in the order they reach the state memory
	task automatic predict_run();
		harmonics_pkg::acc_t acc;
		harmonics_pkg::data_t err;
		harmonics_pkg::data_t new_x1;
		harmonics_pkg::data_t new_x2;
		harmonics_pkg::data_t new_sum;
		int base;
		if (!cleared_m) begin
			for (int h = 0; h < HARMONICS_NUM; h++) begin
				x1_m[h] = '0;
				x2_m[h] = '0;
				push_write(2 * h, '0);
				push_write(2 * h + 1, '0);
			end
			sum_m = '0;
			push_write(SUM_ADDR, '0);
			cleared_m = 1'b1;
		end
		for (int s = 0; s < IN_SERIES_NUM; s++) begin
			err = harmonics_pkg::data_t'(coef_m[SAMPLE_BASE + s] - sum_m);
			new_sum = '0;
			for (int h = 0; h < HARMONICS_NUM; h++) begin
				base = harmonics_pkg::COEF_SLOTS * h;
				// x1 gets cos*x1 - sin*x2 + k1*err
				acc = harmonics_pkg::acc_t'(coef_m[base]) * harmonics_pkg::acc_t'(x1_m[h]);
				acc = acc - harmonics_pkg::acc_t'(coef_m[base + 1]) * harmonics_pkg::acc_t'(x2_m[h]);
				acc = acc + harmonics_pkg::acc_t'(coef_m[base + 2]) * harmonics_pkg::acc_t'(err);
				new_x1 = harmonics_pkg::data_t'(acc >>> QMATH_SHIFT);
				// x2 gets sin*x1 + cos*x2 + k2*err, both from the old state
				acc = harmonics_pkg::acc_t'(coef_m[base + 1]) * harmonics_pkg::acc_t'(x1_m[h]);
				acc = acc + harmonics_pkg::acc_t'(coef_m[base]) * harmonics_pkg::acc_t'(x2_m[h]);
				acc = acc + harmonics_pkg::acc_t'(coef_m[base + 3]) * harmonics_pkg::acc_t'(err);
				new_x2 = harmonics_pkg::data_t'(acc >>> QMATH_SHIFT);
				x1_m[h] = new_x1;
				x2_m[h] = new_x2;
				new_sum = harmonics_pkg::data_t'(new_sum + new_x1);
				push_write(2 * h, new_x1);
				push_write(2 * h + 1, new_x2);
			end
			sum_m = new_sum;
			push_write(SUM_ADDR, sum_m);
		end
	endtask

	`include "harmonics_tb_tasks.svh"

	initial begin
		harmonics_rst = 1'b0;
		start_req = 1'b0;
		coef_wr = '0;
		void'($urandom(SEED));
		apply_reset();
		test_reset_quiet();
		load_coefficients();
		load_samples();
		// first run opens with the clearing pass
		run_estimator(1'b0);
		// second run continues from the stored state while busy writes are dropped
		load_samples();
		run_estimator(1'b1);
		// a new reset brings the clearing pass back, the coefficients stay
		apply_reset();
		test_reset_quiet();
		run_estimator(1'b0);
		if (fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: harmonics_est.f
+incdir+include
design/harmonics_pkg.sv
design/pipeline_delay.sv
design/dual_port_ram.sv
design/slot_addr_gen.sv
design/mac_datapath.sv
design/harmonics_sequencer.sv
design/harmonics_top.sv
tests/harmonics_tb.sv

// File: Makefile
VERILATOR := verilator
TOP := harmonics_tb
RTL_TOP := harmonics_top
FILELIST := harmonics_est.f
VFLAGS := --timing -Wno-fatal
LINT_FLAGS := --lint-only -Wall
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation of $(RTL_TOP) did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
